// ==== logic/renkon_pkg.sv ====
package renkon_pkg;

  localparam int DWIDTH       = 16;
  localparam int FRAC         = DWIDTH / 2;
  localparam int KSIZE        = 5;
  localparam int KAREA        = KSIZE * KSIZE;
  localparam int IMG_SIZE     = 12;
  localparam int FMAP_SIZE    = IMG_SIZE - KSIZE + 1;
  localparam int TREE_LATENCY = 5;  // register stages inside the adder tree

  // pixels, weights and fmap share the Q8.8 format
  typedef logic signed [DWIDTH-1:0]   data_t;
  typedef logic signed [2*DWIDTH-1:0] prod_t;  // full Q16.16 product

  typedef logic [$clog2(IMG_SIZE)-1:0] coord_t;
  typedef logic [$clog2(KAREA)-1:0]    tap_t;  // ky*KSIZE + kx

  typedef enum logic [1:0] {
    S_IDLE,
    S_CONV,
    S_DRAIN
  } ctrl_state_t;

endpackage

// ==== logic/scan_if.sv ====
interface scan_if;

  logic shift;       // one pixel accepted this cycle
  logic clear;       // restart at row 0, column 0
  logic win_full;    // shifted pixel completes a 5x5 window
  logic frame_last;  // shifted pixel is the last of the frame

  modport ctrl (
    output shift, clear,
    input  win_full, frame_last
  );

  modport cnt (
    input  shift, clear,
    output win_full, frame_last
  );

endinterface

// ==== logic/renkon_weight_buf.sv ====
module renkon_weight_buf
  import renkon_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  logic  wreq,
  input  tap_t  waddr,
  input  data_t wdata,
  input  logic  wr_allow,
  output data_t weight [KAREA]
);

  data_t mem [KAREA];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < KAREA; i++) begin
        mem[i] <= '0;
      end
    end else if (wreq && wr_allow && waddr < tap_t'(KAREA)) begin
      mem[waddr] <= wdata;
    end
  end

  for (genvar i = 0; i < KAREA; i++) begin : g_out
    assign weight[i] = mem[i];
  end

  a_waddr_range: assert property (@(posedge clk) disable iff (!xrst)
    (wreq && wr_allow) |-> waddr < tap_t'(KAREA))
    else $error("weight address %0d out of range", waddr);

endmodule

// ==== logic/renkon_window.sv ====
module renkon_window
  import renkon_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  logic  shift,
  input  data_t pixel,
  output data_t window [KAREA]
);

  data_t line_buf [KSIZE-1][IMG_SIZE];  // line_buf[j] ends at row r-1-j
  data_t win      [KSIZE][KSIZE];       // [ky][kx], kx = KSIZE-1 is newest
  data_t new_col  [KSIZE];

  // column entering the window, oldest row first
  always_comb begin
    new_col[KSIZE-1] = pixel;
    for (int j = 0; j < KSIZE - 1; j++) begin
      new_col[KSIZE-2-j] = line_buf[j][IMG_SIZE-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int j = 0; j < KSIZE - 1; j++) begin
        for (int i = 0; i < IMG_SIZE; i++) begin
          line_buf[j][i] <= '0;
        end
      end
      for (int ky = 0; ky < KSIZE; ky++) begin
        for (int kx = 0; kx < KSIZE; kx++) begin
          win[ky][kx] <= '0;
        end
      end
    end else if (shift) begin
      for (int j = 0; j < KSIZE - 1; j++) begin
        line_buf[j][0] <= new_col[KSIZE-1-j];  // pixel or tail of the line above
        for (int i = 1; i < IMG_SIZE; i++) begin
          line_buf[j][i] <= line_buf[j][i-1];
        end
      end
      for (int ky = 0; ky < KSIZE; ky++) begin
        for (int kx = 0; kx < KSIZE - 1; kx++) begin
          win[ky][kx] <= win[ky][kx+1];
        end
        win[ky][KSIZE-1] <= new_col[ky];
      end
    end
  end

  for (genvar ky = 0; ky < KSIZE; ky++) begin : g_row
    for (genvar kx = 0; kx < KSIZE; kx++) begin : g_col
      assign window[ky*KSIZE+kx] = win[ky][kx];
    end
  end

endmodule

// ==== logic/renkon_scan_counter.sv ====
module renkon_scan_counter
  import renkon_pkg::*;
(
  input  logic clk,
  input  logic xrst,
  scan_if.cnt  scan
);

  coord_t row;
  coord_t col;
  logic   col_end;

  assign col_end = (col == coord_t'(IMG_SIZE - 1));

  always_ff @(posedge clk) begin
    if (!xrst) begin
      row <= '0;
      col <= '0;
    end else if (scan.clear) begin
      row <= '0;
      col <= '0;
    end else if (scan.shift) begin
      if (col_end) begin
        col <= '0;
        if (row == coord_t'(IMG_SIZE - 1)) begin
          row <= '0;  // frame done, wait for next clear
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // both refer to the pixel being shifted now
  assign scan.win_full   = (row >= coord_t'(KSIZE - 1)) && (col >= coord_t'(KSIZE - 1));
  assign scan.frame_last = (row == coord_t'(IMG_SIZE - 1)) && col_end;

  a_row_range: assert property (@(posedge clk) disable iff (!xrst)
    row <= coord_t'(IMG_SIZE - 1))
    else $error("scan row %0d beyond image", row);

endmodule

// ==== logic/renkon_conv_ctrl.sv ====
module renkon_conv_ctrl
  import renkon_pkg::*;
(
  input  logic clk,
  input  logic xrst,
  input  logic start,
  input  logic pixel_en,
  scan_if.ctrl scan,
  output logic wr_allow,
  output logic fmap_valid,
  output logic busy,
  output logic done
);

  ctrl_state_t           state;
  logic [TREE_LATENCY:0] vld_dly;  // window stage plus tree stages

  assign scan.clear = (state == S_IDLE) && start;
  assign scan.shift = (state == S_CONV) && pixel_en;

  assign wr_allow   = (state == S_IDLE);
  assign busy       = (state != S_IDLE);
  assign fmap_valid = vld_dly[TREE_LATENCY];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_CONV;
          end
        end
        S_CONV: begin
          if (scan.shift && scan.frame_last) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          if (vld_dly == '0) begin  // last window left the tree
            state <= S_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      vld_dly <= '0;
    end else begin
      vld_dly <= {vld_dly[TREE_LATENCY-1:0], scan.shift & scan.win_full};
    end
  end

  a_done_idle: assert property (@(posedge clk) disable iff (!xrst)
    done |-> !busy && $past(state) == S_DRAIN)
    else $error("done without a drained frame");

  a_shift_busy: assert property (@(posedge clk) disable iff (!xrst)
    scan.shift |=> busy)
    else $error("frame ended right after a shift");

endmodule

// ==== logic/renkon_conv_tree25.sv ====
module renkon_conv_tree25
  import renkon_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  data_t pixel  [KAREA],
  input  data_t weight [KAREA],
  output data_t fmap
);

  data_t r_pixel  [KAREA];
  data_t r_weight [KAREA];
  prod_t r_prod   [KAREA];
  data_t r_term   [KAREA];    // rounded products
  data_t sum0     [KAREA/2];  // 12 pairs, tap 24 left over
  data_t sum1     [KAREA/4];
  data_t sum2     [KAREA/8];
  data_t r_sum2   [KAREA/8];
  data_t r_term24_d;
  data_t sum_final;
  data_t r_fmap;

  // keep Q8.8 from a Q16.16 product, negative exact values shifted down by one lsb
  function automatic data_t round_prod(input prod_t p);
    logic [DWIDTH-2:0] mag;
    mag = p[DWIDTH+FRAC-2:FRAC];
    if (p[DWIDTH+FRAC-2] && p[FRAC-1:0] == '0) begin
      mag = mag - 1'b1;
    end
    return {p[DWIDTH+FRAC-2], mag};
  endfunction

  for (genvar i = 0; i < KAREA / 2; i++) begin : g_lvl0
    assign sum0[i] = r_term[2*i] + r_term[2*i+1];
  end

  for (genvar i = 0; i < KAREA / 4; i++) begin : g_lvl1
    assign sum1[i] = sum0[2*i] + sum0[2*i+1];
  end

  for (genvar i = 0; i < KAREA / 8; i++) begin : g_lvl2
    assign sum2[i] = sum1[2*i] + sum1[2*i+1];
  end

  assign sum_final = (r_sum2[0] + r_sum2[1]) + (r_sum2[2] + r_term24_d);

  // stages 1 to 3: operands, products, rounded terms
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < KAREA; i++) begin
        r_pixel[i]  <= '0;
        r_weight[i] <= '0;
        r_prod[i]   <= '0;
        r_term[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < KAREA; i++) begin
        r_pixel[i]  <= pixel[i];
        r_weight[i] <= weight[i];
        r_prod[i]   <= r_pixel[i] * r_weight[i];
        r_term[i]   <= round_prod(r_prod[i]);
      end
    end
  end

  // stage 4: three level-2 partial sums next to the odd tap
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < KAREA / 8; i++) begin
        r_sum2[i] <= '0;
      end
      r_term24_d <= '0;
    end else begin
      for (int i = 0; i < KAREA / 8; i++) begin
        r_sum2[i] <= sum2[i];
      end
      r_term24_d <= r_term[KAREA-1];
    end
  end

  // stage 5
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fmap <= '0;
    end else begin
      r_fmap <= sum_final;  // wraps modulo 2^16
    end
  end

  assign fmap = r_fmap;

endmodule

// ==== logic/renkon_conv_core.sv ====
module renkon_conv_core
  import renkon_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  logic  start,
  input  logic  wreq,
  input  tap_t  waddr,
  input  data_t wdata,
  input  logic  pixel_en,
  input  data_t pixel,
  output data_t fmap,
  output logic  fmap_valid,
  output logic  busy,
  output logic  done
);

  scan_if scan ();

  logic  wr_allow;
  data_t window [KAREA];
  data_t weight [KAREA];

  renkon_conv_ctrl u_ctrl (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .pixel_en   (pixel_en),
    .scan       (scan.ctrl),
    .wr_allow   (wr_allow),
    .fmap_valid (fmap_valid),
    .busy       (busy),
    .done       (done)
  );

  renkon_scan_counter u_scan (
    .clk  (clk),
    .xrst (xrst),
    .scan (scan.cnt)
  );

  renkon_weight_buf u_weight (
    .clk      (clk),
    .xrst     (xrst),
    .wreq     (wreq),
    .waddr    (waddr),
    .wdata    (wdata),
    .wr_allow (wr_allow),
    .weight   (weight)
  );

  renkon_window u_window (
    .clk    (clk),
    .xrst   (xrst),
    .shift  (scan.shift),  // same strobe that advances the counter
    .pixel  (pixel),
    .window (window)
  );

  renkon_conv_tree25 u_tree (
    .clk    (clk),
    .xrst   (xrst),
    .pixel  (window),
    .weight (weight),
    .fmap   (fmap)
  );

endmodule

// ==== tb/tb_renkon_conv_core.sv ====
module tb_renkon_conv_core
  import renkon_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NOUT         = FMAP_SIZE * FMAP_SIZE;
  localparam int          NPIX         = IMG_SIZE * IMG_SIZE;
  localparam int          VALID_EDGES  = 6;  // counts the accepting edge
  localparam int          RESET_CYCLES = 8;
  localparam int          DONE_TIMEOUT = 200;
  localparam int          STRAY_IDX    = 70;
  localparam int          N_FRAMES     = 7;
  localparam logic [31:0] LFSR_SEED    = 32'h83cc;
  localparam logic [31:0] LFSR_POLY    = 32'h8020_0003;

  typedef enum logic [1:0] {W_IDENT, W_CONST, W_RAND, W_KEEP} wmode_t;
  typedef enum logic [1:0] {P_RAMP, P_RAND, P_KEEP} pmode_t;
  typedef struct packed {
    wmode_t wmode;
    pmode_t pmode;
    logic   gaps;
    logic   stray;  // start and weight write while busy
  } frame_case_t;

  // frames with W_KEEP / P_KEEP reuse the previous weights / image
  frame_case_t cases [N_FRAMES] = '{
    '{W_IDENT, P_RAMP, 1'b0, 1'b0},
    '{W_KEEP,  P_KEEP, 1'b1, 1'b0},
    '{W_RAND,  P_RAND, 1'b0, 1'b0},
    '{W_KEEP,  P_KEEP, 1'b1, 1'b0},
    '{W_CONST, P_RAND, 1'b1, 1'b1},
    '{W_KEEP,  P_RAND, 1'b0, 1'b0},
    '{W_RAND,  P_RAND, 1'b1, 1'b1}
  };

  logic  clk, xrst, start, wreq, pixel_en, fmap_valid, busy, done;
  tap_t  waddr;
  data_t wdata, pixel, fmap;

  data_t       img [NPIX];
  data_t       w_cur [KAREA];
  data_t       exp_map [NOUT];
  int          acc_q [$];  // accepting edge of each window-completing pixel
  int          edge_cnt = 0;
  int          out_cnt, done_seen, acc_edge;
  int          corner_hits = 0;
  logic [31:0] lfsr = LFSR_SEED;

  renkon_conv_core dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic fail_value(input string sig, input int expv, input int actv);
    $display("Error: time %0t, %s expected %0d, actual %0d", $time, sig, expv, actv);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Q16.16 product back to Q8.8, exact negative values drop one lsb
  function automatic data_t round_term(input prod_t p);
    logic signed [14:0] field;
    data_t              t;
    field = p[22:FRAC];
    t = data_t'(field);
    if (p[22] && p[FRAC-1:0] == '0) begin
      t = t - data_t'(1);
      corner_hits++;
    end
    return t;
  endfunction

  task automatic build_expected(input logic ident);
    data_t sum;
    for (int r = 0; r < FMAP_SIZE; r++) begin
      for (int c = 0; c < FMAP_SIZE; c++) begin
        sum = '0;
        for (int k = 0; k < KAREA; k++) begin
          sum = sum + round_term(prod_t'(img[(r + k / KSIZE) * IMG_SIZE + c + k % KSIZE])
                                 * prod_t'(w_cur[k]));
        end
        if (ident) begin
          sum = img[(r + 2) * IMG_SIZE + c + 2];  // center tap passes the pixel through
        end
        exp_map[r * FMAP_SIZE + c] = sum;
      end
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #5;
    pixel_en = 1'b0;
    start    = 1'b0;
    wreq     = 1'b0;
  endtask

  task automatic load_weights();
    for (int k = 0; k < KAREA; k++) begin
      @(posedge clk);
      #5;
      wreq  = 1'b1;
      waddr = tap_t'(k);
      wdata = w_cur[k];
    end
    idle_cycle();
  endtask

  task automatic wait_frame_done(input int f);
    int n;
    n = 0;
    while (done_seen == 0) begin
      @(posedge clk);
      n++;
      if (n > DONE_TIMEOUT) begin
        fail_plain($sformatf("timeout waiting for done in frame %0d", f));
      end
    end
  endtask

  task automatic run_frame(input int f, input frame_case_t fc);
    int mag;
    for (int k = 0; k < KAREA; k++) begin
      case (fc.wmode)
        W_IDENT: w_cur[k] = (k == KAREA / 2) ? data_t'(256) : data_t'(0);
        W_CONST: w_cur[k] = data_t'(16);
        W_RAND: begin
          if (k % KSIZE == 2) begin  // integer taps reach the rounding corner
            mag = (rand_bits(1) + 1) * 256;
            w_cur[k] = rand_bits(1) ? data_t'(-mag) : data_t'(mag);
          end else begin
            w_cur[k] = data_t'(rand_bits(10) - 512);
          end
        end
        default: ;
      endcase
    end
    for (int i = 0; i < NPIX; i++) begin
      case (fc.pmode)
        P_RAMP:  img[i] = data_t'(i * 32);
        P_RAND:  img[i] = data_t'(rand_bits(11) - 1024);
        default: ;
      endcase
    end
    if (fc.wmode != W_KEEP) begin
      load_weights();
    end
    build_expected(fc.wmode == W_IDENT);
    out_cnt   = 0;
    done_seen = 0;
    acc_q.delete();
    @(posedge clk);
    #5 start = 1'b1;
    for (int idx = 0; idx < NPIX; idx++) begin
      if (fc.stray && idx == STRAY_IDX) begin
        @(posedge clk);
        #5;
        pixel_en = 1'b0;
        start    = 1'b1;
        wreq     = 1'b1;
        waddr    = tap_t'(KAREA / 2);
        wdata    = 16'sh7fff;
      end
      if (fc.gaps && idx > 0) begin
        repeat (rand_bits(2)) idle_cycle();
      end
      @(posedge clk);
      #5;
      start    = 1'b0;
      wreq     = 1'b0;
      pixel_en = 1'b1;
      pixel    = img[idx];
      if (idx / IMG_SIZE >= KSIZE - 1 && idx % IMG_SIZE >= KSIZE - 1) begin
        acc_q.push_back(edge_cnt + 1);
      end
    end
    idle_cycle();
    wait_frame_done(f);
  endtask

  always @(negedge clk) begin
    if (xrst && fmap_valid) begin
      assert (acc_q.size() > 0) else fail_plain("fmap_valid without a completed window");
      acc_edge = acc_q.pop_front();
      assert (edge_cnt - acc_edge + 1 == VALID_EDGES)
        else fail_value("fmap_valid edge", acc_edge + VALID_EDGES - 1, edge_cnt);
      assert (busy == 1'b1) else fail_value("busy", 1, busy);
      assert (out_cnt < NOUT) else fail_plain("more than 64 outputs in one frame");
      assert (fmap == exp_map[out_cnt])
        else fail_value($sformatf("fmap[%0d]", out_cnt), exp_map[out_cnt], fmap);
      out_cnt++;
    end
    if (xrst && done) begin
      assert (busy == 1'b0) else fail_value("busy", 0, busy);
      assert (out_cnt == NOUT) else fail_value("fmap_valid count", NOUT, out_cnt);
      assert (done_seen == 0) else fail_plain("second done pulse in one frame");
      done_seen++;
    end
  end

  initial begin
    xrst     = 1'b0;
    start    = 1'b0;
    wreq     = 1'b0;
    waddr    = '0;
    wdata    = '0;
    pixel_en = 1'b0;
    pixel    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5 xrst = 1'b1;
    @(negedge clk);
    assert (busy == 1'b0) else fail_value("busy", 0, busy);
    assert (done == 1'b0) else fail_value("done", 0, done);
    assert (fmap_valid == 1'b0) else fail_value("fmap_valid", 0, fmap_valid);
    assert (fmap == '0) else fail_value("fmap", 0, fmap);
    for (int f = 0; f < N_FRAMES; f++) begin
      run_frame(f, cases[f]);
    end
    assert (corner_hits > 0) else fail_plain("rounding corner never exercised");
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
logic/renkon_pkg.sv
logic/scan_if.sv
logic/renkon_weight_buf.sv
logic/renkon_window.sv
logic/renkon_scan_counter.sv
logic/renkon_conv_ctrl.sv
logic/renkon_conv_tree25.sv
logic/renkon_conv_core.sv
tb/tb_renkon_conv_core.sv

// ==== Bender.yml ====
package:
  name: renkon_conv

sources:
  - files:
      - logic/renkon_pkg.sv
      - logic/scan_if.sv
      - logic/renkon_weight_buf.sv
      - logic/renkon_window.sv
      - logic/renkon_scan_counter.sv
      - logic/renkon_conv_ctrl.sv
      - logic/renkon_conv_tree25.sv
      - logic/renkon_conv_core.sv
  - target: test
    files:
      - tb/tb_renkon_conv_core.sv
